// File: common/readout_pkg.sv
package readout_pkg;

    // ----------------------------------------
    // data widths
    // ----------------------------------------
    typedef logic [7:0]  byte_t;           // one ADC sample byte or TCP tx byte
    typedef logic [3:0]  channel_cnt_t;    // enabled ADC channels
    typedef logic [31:0] word_t;           // rbcp register contents
    typedef logic [31:0] rbcp_addr_t;      // rbcp address as given by the TCP core
    typedef logic [6:0]  fifo_count_t;     // fill level, 0 up to FIFO_DEPTH
    typedef logic [5:0]  budget_t;         // bytes left in one release, max 60
    typedef logic [3:0]  credit_t;         // tx credits held by the pacer
    typedef logic [15:0] delay_cnt_t;      // pacer delay counter

    // ----------------------------------------
    // sizes and timing
    // ----------------------------------------
    localparam int FIFO_DEPTH = 64;                    // byte fifo entries

    // 4 bytes go out per enabled channel on every release
    localparam budget_t BYTES_PER_CHANNEL = 6'd4;

    // trigger to release delay, kept short for simulation
    localparam delay_cnt_t READ_DELAY_CYCLES = 16'd200;

    localparam credit_t TX_CREDITS = 4'd8;             // credits after reset or flush

    // ----------------------------------------
    // pacer FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        PACER_IDLE,     // waiting for a fifo write
        PACER_WAIT,     // counting down the read delay
        PACER_DRAIN     // sending the byte budget
    } pacer_state_e;

endpackage

// File: readout/readout_pacer.sv
module readout_pacer (
    input  logic                      CLK_200M,
    input  logic                      CNT125M,
    input  logic                      tcp_open_i,       // low aborts everything
    input  logic                      trigger_i,        // fifo write strobe
    input  readout_pkg::channel_cnt_t rd_channels_i,
    input  logic                      fifo_empty_i,
    input  readout_pkg::byte_t        fifo_data_i,      // registered fifo output
    output logic                      fifo_rd_en_o,
    input  logic                      credit_return_i,  // one credit back per cycle
    output logic                      tx_valid_o,
    output readout_pkg::byte_t        tx_data_o
);

    readout_pkg::pacer_state_e state;
    readout_pkg::delay_cnt_t   delay_cnt;   // cycles left before release
    readout_pkg::budget_t      budget;      // bytes left in this release
    readout_pkg::credit_t      credits;     // bytes the TCP side can still take

    // ----------------------------------------
    // read issue
    // ----------------------------------------
    // one read per cycle while draining, only with budget, data and a credit
    assign fifo_rd_en_o = (state == readout_pkg::PACER_DRAIN) &
                          (budget != '0) &
                          (credits != '0) &
                          ~fifo_empty_i;

    assign tx_data_o = fifo_data_i;         // fifo data lands with tx_valid_o

    // ----------------------------------------
    // FSM, delay and budget
    // ----------------------------------------
    always_ff @(posedge CLK_200M or posedge CNT125M) begin
        if (CNT125M) begin
            state     <= readout_pkg::PACER_IDLE;
            delay_cnt <= '0;
            budget    <= '0;
        end else if (!tcp_open_i) begin
            state     <= readout_pkg::PACER_IDLE;   // connection lost
            delay_cnt <= '0;
            budget    <= '0;
        end else begin
            case (state)
                readout_pkg::PACER_IDLE: begin
                    if (trigger_i) begin
                        delay_cnt <= readout_pkg::READ_DELAY_CYCLES;
                        state     <= readout_pkg::PACER_WAIT;
                    end
                end
                readout_pkg::PACER_WAIT: begin
                    if (delay_cnt == '0) begin
                        // 4 bytes per enabled channel
                        budget <= readout_pkg::BYTES_PER_CHANNEL *
                                  readout_pkg::budget_t'(rd_channels_i);
                        state  <= readout_pkg::PACER_DRAIN;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                readout_pkg::PACER_DRAIN: begin
                    if (budget == '0) begin
                        state <= readout_pkg::PACER_IDLE;   // release done
                    end else if (fifo_rd_en_o) begin
                        budget <= budget - 1'b1;
                    end
                end
                default: begin
                    state <= readout_pkg::PACER_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // credits and tx strobe
    // ----------------------------------------
    always_ff @(posedge CLK_200M or posedge CNT125M) begin
        if (CNT125M) begin
            credits    <= readout_pkg::TX_CREDITS;
            tx_valid_o <= 1'b0;
        end else if (!tcp_open_i) begin
            credits    <= readout_pkg::TX_CREDITS;  // fresh connection, full window
            tx_valid_o <= 1'b0;                     // fifo flushed, nothing to send
        end else begin
            tx_valid_o <= fifo_rd_en_o;             // read data valid next cycle
            case ({fifo_rd_en_o, credit_return_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;        // spent and returned together
            endcase
        end
    end

endmodule

// File: readout/sample_fifo.sv
module sample_fifo (
    input  logic               CLK_200M,
    input  logic               CNT125M,
    input  logic               flush_i,      // connection closed, drop everything
    input  logic               wr_en_i,
    input  readout_pkg::byte_t wr_data_i,
    input  logic               rd_en_i,
    output readout_pkg::byte_t rd_data_o,    // valid one cycle after rd_en_i
    output logic               empty_o,
    output logic               full_o
);

    readout_pkg::byte_t                         mem [readout_pkg::FIFO_DEPTH];
    logic [$clog2(readout_pkg::FIFO_DEPTH)-1:0] wr_ptr;     // wraps at depth
    logic [$clog2(readout_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    readout_pkg::fifo_count_t                   count;      // entries stored
    logic                                       wr_ok;      // write really happens
    logic                                       rd_ok;      // read really happens

    assign full_o  = (count == readout_pkg::fifo_count_t'(readout_pkg::FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign wr_ok   = wr_en_i & ~full_o & ~flush_i;   // byte dropped when full
    assign rd_ok   = rd_en_i & ~empty_o & ~flush_i;

    // ----------------------------------------
    // storage and read data
    // ----------------------------------------
    always_ff @(posedge CLK_200M) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (rd_ok) begin
            rd_data_o <= mem[rd_ptr];       // holds its value between reads
        end
    end

    // ----------------------------------------
    // pointers and fill level
    // ----------------------------------------
    always_ff @(posedge CLK_200M or posedge CNT125M) begin
        if (CNT125M) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;                   // empty again after close
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or both in one cycle
            endcase
        end
    end

endmodule

// File: readout_top.f
common/readout_pkg.sv
readout/sample_fifo.sv
readout/readout_pacer.sv
src/rbcp_regs.sv
src/readout_top.sv
sim/readout_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the readout testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=readout_top_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module readout_top_tb \
    -f readout_top.f \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// File: sim/readout_top_tb.sv
module readout_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WATCHDOG_CYCLES = 20000;     // a few thousand cycles of tests plus margin
    localparam int QUIET_CYCLES    = int'(readout_pkg::READ_DELAY_CYCLES) + 2;
    localparam int CREDITS         = int'(readout_pkg::TX_CREDITS);

    logic                      CLK_200M       = 1'b0;
    logic                      CNT125M        = 1'b1;   // held for the first 4 cycles
    logic                      sample_valid   = 1'b0;
    readout_pkg::byte_t        sample_data    = 8'h00;
    readout_pkg::channel_cnt_t rd_channels    = 4'd0;
    logic                      tcp_open       = 1'b1;
    logic                      credit_return  = 1'b0;
    readout_pkg::rbcp_addr_t   rbcp_addr      = 32'h0;
    readout_pkg::byte_t        rbcp_wd        = 8'h00;
    logic                      rbcp_we        = 1'b0;
    logic                      rbcp_re        = 1'b0;
    logic                      tx_valid;
    logic                      fifo_full;
    logic                      rbcp_ack;
    readout_pkg::byte_t        tx_data;
    readout_pkg::byte_t        rbcp_rd;

    readout_pkg::byte_t exp_q[$];       // accepted bytes in arrival order
    integer seed            = 32'h29f3;
    int     errors          = 0;
    int     errors_at_start = 0;
    int     tests_passed    = 0;
    int     tests_failed    = 0;
    int     sent            = 0;        // bytes seen on tx
    int     returned        = 0;        // credits handed back
    logic   withhold        = 1'b0;     // TCP side keeps its credits
    logic   arm_quiet       = 1'b0;     // marks a trigger from idle
    int     quiet_left      = 0;        // cycles that must stay without tx_valid

    always #20 CLK_200M = ~CLK_200M;

    readout_top readout_top_inst (
        .CLK_200M        (CLK_200M),
        .CNT125M         (CNT125M),
        .sample_valid_i  (sample_valid),
        .sample_data_i   (sample_data),
        .rd_channels_i   (rd_channels),
        .fifo_full_o     (fifo_full),
        .tcp_open_i      (tcp_open),
        .credit_return_i (credit_return),
        .tx_valid_o      (tx_valid),
        .tx_data_o       (tx_data),
        .rbcp_addr_i     (rbcp_addr),
        .rbcp_wd_i       (rbcp_wd),
        .rbcp_we_i       (rbcp_we),
        .rbcp_re_i       (rbcp_re),
        .rbcp_rd_o       (rbcp_rd),
        .rbcp_ack_o      (rbcp_ack)
    );

    function automatic void note_failure(input string msg);
        $display("%s", msg);
        errors++;
    endfunction

    function automatic void check_eq(input string what, input int got, input int expct);
        assert (got == expct) else begin
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, expct);
            errors++;
        end
    endfunction

    // ----------------------------------------
    // TCP side and tx monitor
    // ----------------------------------------
    always @(posedge CLK_200M) begin
        if (!tcp_open) begin
            returned = sent;                // window refilled on close
            credit_return <= 1'b0;
        end else if (!withhold && returned < sent && ($random(seed) & 1) == 1) begin
            returned++;                     // random return delay
            credit_return <= 1'b1;
        end else begin
            credit_return <= 1'b0;
        end
        if (arm_quiet) quiet_left <= QUIET_CYCLES;
        else if (quiet_left != 0) quiet_left <= quiet_left - 1;
    end

    always @(negedge CLK_200M) begin
        if (tx_valid) begin
            sent++;
            if (exp_q.size() == 0) note_failure("a byte was sent that was never accepted");
            else check_eq("tx_data_o", int'(tx_data), int'(exp_q.pop_front()));
        end
    end

    // ----------------------------------------
    // protocol assertions
    // ----------------------------------------
    no_early_tx: assert property (@(posedge CLK_200M) disable iff (CNT125M)
        quiet_left != 0 |-> !tx_valid)
        else note_failure("tx_valid_o came before the read delay had passed");
    credit_window: assert property (@(posedge CLK_200M) disable iff (CNT125M)
        sent - returned <= CREDITS)
        else note_failure("more bytes sent than the credit window allows");
    ack_after_access: assert property (@(posedge CLK_200M) disable iff (CNT125M)
        (rbcp_we || rbcp_re) |=> rbcp_ack)
        else note_failure("rbcp_ack_o missing one cycle after an access");
    no_stray_ack: assert property (@(posedge CLK_200M) disable iff (CNT125M)
        !(rbcp_we || rbcp_re) |=> !rbcp_ack)
        else note_failure("rbcp_ack_o high without an access before it");
    quiet_when_closed: assert property (@(posedge CLK_200M) disable iff (CNT125M)
        !tcp_open |=> !tx_valid)
        else note_failure("tx_valid_o high while the connection was closed");

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------
    task automatic write_bytes(input int n, input int keep, input readout_pkg::channel_cnt_t ch);
        readout_pkg::byte_t b;
        for (int i = 0; i < n; i++) begin
            @(posedge CLK_200M);
            b = readout_pkg::byte_t'($random(seed));
            sample_valid <= 1'b1;
            sample_data  <= b;
            rd_channels  <= ch;
            arm_quiet    <= (i == 0);       // every call starts from an idle pacer
            if (i < keep) exp_q.push_back(b);   // past keep the fifo is full
        end
        @(posedge CLK_200M);
        sample_valid <= 1'b0;
        arm_quiet    <= 1'b0;
    endtask

    task automatic wait_sent(input int target, input int limit);
        int n;
        n = 0;
        while (sent < target && n < limit) begin
            @(posedge CLK_200M);
            n++;
        end
        if (sent < target) begin
            note_failure($sformatf("only %0d of %0d bytes were sent", sent, target));
        end
        repeat (4) @(posedge CLK_200M);     // pacer back to idle
    endtask

    task automatic wait_tx_started(input int base, input int limit);
        int n;
        n = 0;
        while (sent == base && n < limit) begin
            @(posedge CLK_200M);
            n++;
        end
        if (sent == base) note_failure("no byte was sent before the connection closed");
    endtask

    task automatic wait_credits_back(input int limit);
        int n;
        n = 0;
        while (returned < sent && n < limit) begin
            @(posedge CLK_200M);
            n++;
        end
        if (returned < sent) note_failure("the TCP side model kept credits too long");
        repeat (2) @(posedge CLK_200M);
    endtask

    task automatic rbcp_access(input readout_pkg::rbcp_addr_t addr,
                               input readout_pkg::byte_t wd, input logic write);
        @(posedge CLK_200M);
        rbcp_addr <= addr;
        rbcp_wd   <= wd;
        rbcp_we   <= write;
        rbcp_re   <= !write;
        @(posedge CLK_200M);
        rbcp_we <= 1'b0;
        rbcp_re <= 1'b0;
        @(negedge CLK_200M);                // ack and lane registered by now
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        readout_pkg::word_t      word;
        readout_pkg::rbcp_addr_t addr;
        readout_pkg::byte_t      wd;
        int                      base;
        repeat (4) @(posedge CLK_200M);
        CNT125M <= 1'b0;
        @(negedge CLK_200M);
        check_eq("tx_valid_o", int'(tx_valid), 0);
        check_eq("rbcp_ack_o", int'(rbcp_ack), 0);
        check_eq("fifo_full_o", int'(fifo_full), 0);
        end_test("reset");

        base = sent;
        write_bytes(8, 8, 4'd2);
        wait_sent(base + 8, 1000);
        check_eq("bytes left to send", exp_q.size(), 0);
        end_test("delay and order");

        base = sent;
        write_bytes(12, 12, 4'd2);          // only 8 go out and 4 stay buffered
        wait_sent(base + 8, 1000);
        repeat (QUIET_CYCLES + 20) @(posedge CLK_200M);
        check_eq("bytes in one release", sent - base, 8);
        write_bytes(4, 4, 4'd2);
        wait_sent(base + 16, 1000);
        wait_credits_back(500);
        withhold <= 1'b1;
        base = sent;
        write_bytes(16, 16, 4'd4);
        wait_sent(base + CREDITS, 1000);
        repeat (30) @(posedge CLK_200M);
        check_eq("bytes sent with credits withheld", sent - base, CREDITS);
        withhold <= 1'b0;
        wait_sent(base + 16, 1000);
        check_eq("bytes left to send", exp_q.size(), 0);
        end_test("byte budget and credits");

        base = sent;
        write_bytes(6, 6, 4'd2);
        wait_tx_started(base, 1000);
        tcp_open <= 1'b0;                   // close in the middle of a release
        repeat (3) @(posedge CLK_200M);
        exp_q.delete();                     // stale bytes are gone
        tcp_open <= 1'b1;
        base = sent;
        write_bytes(8, 8, 4'd2);
        wait_sent(base + 8, 1000);
        check_eq("bytes left to send", exp_q.size(), 0);
        end_test("flush");

        base = sent;
        write_bytes(readout_pkg::FIFO_DEPTH + 6, readout_pkg::FIFO_DEPTH, 4'd15);
        @(negedge CLK_200M);
        check_eq("fifo_full_o", int'(fifo_full), 1);
        wait_sent(base + 60, 2000);
        write_bytes(1, 1, 4'd2);            // last stored bytes go out ahead of it
        wait_sent(base + readout_pkg::FIFO_DEPTH + 1, 1000);
        check_eq("bytes left to send", exp_q.size(), 0);
        @(posedge CLK_200M);
        tcp_open <= 1'b0;
        repeat (3) @(posedge CLK_200M);
        tcp_open <= 1'b1;
        @(negedge CLK_200M);
        check_eq("fifo_full_o once drained", int'(fifo_full), 0);
        end_test("full fifo");

        for (int r = 0; r < 2; r++) begin
            addr = readout_pkg::rbcp_addr_t'($random(seed));
            wd   = readout_pkg::byte_t'($random(seed));
            word = (addr & 32'hffff_fffc) + (32'(wd) * 32'h0101_0101);
            rbcp_access(addr, wd, 1'b1);
            for (int lane = 0; lane < 4; lane++) begin
                rbcp_access({addr[31:2], 2'(lane)}, 8'h00, 1'b0);
                check_eq($sformatf("rbcp_rd_o lane %0d", lane), int'(rbcp_rd),
                         int'(word[lane*8 +: 8]));
            end
        end
        repeat (2) @(posedge CLK_200M);
        end_test("rbcp");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK_200M);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// File: src/rbcp_regs.sv
module rbcp_regs (
    input  logic                    CLK_200M,
    input  logic                    CNT125M,
    input  readout_pkg::rbcp_addr_t rbcp_addr_i,
    input  readout_pkg::byte_t      rbcp_wd_i,
    input  logic                    rbcp_we_i,
    input  logic                    rbcp_re_i,
    output readout_pkg::byte_t      rbcp_rd_o,     // lane picked by addr[1:0]
    output logic                    rbcp_ack_o     // one cycle after any access
);

    readout_pkg::word_t offset_reg;     // test register, aligned addr + data

    // ----------------------------------------
    // register write and acknowledge
    // ----------------------------------------
    always_ff @(posedge CLK_200M or posedge CNT125M) begin
        if (CNT125M) begin
            offset_reg <= '0;
            rbcp_ack_o <= 1'b0;
        end else begin
            if (rbcp_we_i) begin
                // word aligned address plus the byte copied into all lanes
                offset_reg <= {rbcp_addr_i[31:2], 2'b00} + {4{rbcp_wd_i}};
            end
            rbcp_ack_o <= rbcp_re_i | rbcp_we_i;
        end
    end

    // ----------------------------------------
    // byte lane read back
    // ----------------------------------------
    always_ff @(posedge CLK_200M) begin
        rbcp_rd_o <= offset_reg[rbcp_addr_i[1:0]*8 +: 8];   // lane 0 is lsb
    end

endmodule

// File: src/readout_top.sv
module readout_top (
    input  logic                      CLK_200M,
    input  logic                      CNT125M,
    // sample input
    input  logic                      sample_valid_i,
    input  readout_pkg::byte_t        sample_data_i,
    input  readout_pkg::channel_cnt_t rd_channels_i,    // bytes per release / 4
    output logic                      fifo_full_o,
    // TCP transmit side
    input  logic                      tcp_open_i,
    input  logic                      credit_return_i,
    output logic                      tx_valid_o,
    output readout_pkg::byte_t        tx_data_o,
    // RBCP slow control
    input  readout_pkg::rbcp_addr_t   rbcp_addr_i,
    input  readout_pkg::byte_t        rbcp_wd_i,
    input  logic                      rbcp_we_i,
    input  logic                      rbcp_re_i,
    output readout_pkg::byte_t        rbcp_rd_o,
    output logic                      rbcp_ack_o
);

    logic               fifo_wr_en;     // also the pacer trigger
    logic               fifo_flush;
    logic               fifo_rd_en;
    logic               fifo_empty;
    readout_pkg::byte_t fifo_data;

    // ----------------------------------------
    // byte path
    // ----------------------------------------
    assign fifo_wr_en = sample_valid_i & tcp_open_i;    // no writes while closed
    assign fifo_flush = ~tcp_open_i;

    sample_fifo sample_fifo_inst (
        .CLK_200M  (CLK_200M),
        .CNT125M   (CNT125M),
        .flush_i   (fifo_flush),
        .wr_en_i   (fifo_wr_en),
        .wr_data_i (sample_data_i),
        .rd_en_i   (fifo_rd_en),
        .rd_data_o (fifo_data),
        .empty_o   (fifo_empty),
        .full_o    (fifo_full_o)
    );

    readout_pacer readout_pacer_inst (
        .CLK_200M        (CLK_200M),
        .CNT125M         (CNT125M),
        .tcp_open_i      (tcp_open_i),
        .trigger_i       (fifo_wr_en),
        .rd_channels_i   (rd_channels_i),
        .fifo_empty_i    (fifo_empty),
        .fifo_data_i     (fifo_data),
        .fifo_rd_en_o    (fifo_rd_en),
        .credit_return_i (credit_return_i),
        .tx_valid_o      (tx_valid_o),
        .tx_data_o       (tx_data_o)
    );

    // ----------------------------------------
    // slow control
    // ----------------------------------------
    rbcp_regs rbcp_regs_inst (
        .CLK_200M    (CLK_200M),
        .CNT125M     (CNT125M),
        .rbcp_addr_i (rbcp_addr_i),
        .rbcp_wd_i   (rbcp_wd_i),
        .rbcp_we_i   (rbcp_we_i),
        .rbcp_re_i   (rbcp_re_i),
        .rbcp_rd_o   (rbcp_rd_o),
        .rbcp_ack_o  (rbcp_ack_o)
    );

endmodule
